// ==== hdl/mul_pkg.sv ====
package mul_pkg;

  localparam int XLEN       = 64;
  localparam int PROD_W     = 2 * XLEN;
  localparam int EXT_W      = XLEN + 2;  // even number of booth bit pairs
  localparam int PP_NUM     = EXT_W / 2;
  localparam int TREE_DEPTH = 8;         // 33 rows down to 2

  // controller states
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_BOOTH = 2'd1;
  localparam logic [1:0] ST_WAIT  = 2'd2;

  // full word for mul, halves for the mulh family
  typedef union packed {
    logic [PROD_W-1:0] full;
    struct packed {
      logic [XLEN-1:0] hi;
      logic [XLEN-1:0] lo;
    } half;
  } product_u;

  // rows left after one 3:2 layer
  function automatic int csa_out_rows(input int in_rows);
    int groups;
    groups = in_rows / 3;
    return 2 * groups + (in_rows % 3);
  endfunction

endpackage

// ==== hdl/mul_csa_layer.sv ====
`timescale 1ns/1ps

module mul_csa_layer #(
  parameter int IN_ROWS = 3
) (
  input  logic [mul_pkg::PROD_W-1:0] rows_i [IN_ROWS],
  output logic [mul_pkg::PROD_W-1:0] rows_o [mul_pkg::csa_out_rows(IN_ROWS)]
);

  localparam int PROD_W = mul_pkg::PROD_W;
  localparam int GROUPS = IN_ROWS / 3;
  localparam int LEFT   = IN_ROWS % 3;

  for (genvar g = 0; g < GROUPS; g++) begin : g_group
    logic [PROD_W-1:0] a;
    logic [PROD_W-1:0] b;
    logic [PROD_W-1:0] c;
    logic [PROD_W-1:0] carry;

    assign a = rows_i[3*g];
    assign b = rows_i[3*g+1];
    assign c = rows_i[3*g+2];

    // bitwise full adder
    assign carry = (a & b) | (a & c) | (b & c);
    assign rows_o[2*g]   = a ^ b ^ c;
    assign rows_o[2*g+1] = {carry[PROD_W-2:0], 1'b0};  // top carry dropped
  end

  // rows that do not fill a group ride along unchanged
  for (genvar l = 0; l < LEFT; l++) begin : g_pass
    assign rows_o[2*GROUPS+l] = rows_i[3*GROUPS+l];
  end

endmodule

// ==== hdl/mul_booth_r4.sv ====
`timescale 1ns/1ps

module mul_booth_r4 (
  input  logic [mul_pkg::XLEN-1:0]   op1_i,
  input  logic [mul_pkg::XLEN-1:0]   op2_i,
  input  logic                       op1_signed_i,
  input  logic                       op2_signed_i,
  output logic [mul_pkg::PROD_W-1:0] pp_o [mul_pkg::PP_NUM]
);

  localparam int XLEN   = mul_pkg::XLEN;
  localparam int EXT_W  = mul_pkg::EXT_W;
  localparam int PROD_W = mul_pkg::PROD_W;

  logic [EXT_W-1:0]  op1_ext;   // multiplicand
  logic [EXT_W-1:0]  op2_ext;   // multiplier
  logic [EXT_W:0]    op2_pad;   // implicit zero below bit 0

  logic [PROD_W-1:0] mcand_pos;
  logic [PROD_W-1:0] mcand_dbl;
  logic [PROD_W-1:0] mcand_neg;
  logic [PROD_W-1:0] mcand_neg_dbl;

  // extension by the operand's own signed flag
  assign op1_ext = {{(EXT_W - XLEN){op1_signed_i & op1_i[XLEN-1]}}, op1_i};
  assign op2_ext = {{(EXT_W - XLEN){op2_signed_i & op2_i[XLEN-1]}}, op2_i};
  assign op2_pad = {op2_ext, 1'b0};

  // the four nonzero multiples, all sign extended to the product width
  assign mcand_pos     = {{(PROD_W - EXT_W){op1_ext[EXT_W-1]}}, op1_ext};
  assign mcand_dbl     = {mcand_pos[PROD_W-2:0], 1'b0};
  assign mcand_neg     = ~mcand_pos + 1'b1;
  assign mcand_neg_dbl = ~mcand_dbl + 1'b1;

  always_comb begin
    logic [2:0]        win;
    logic [PROD_W-1:0] mult;
    for (int j = 0; j < mul_pkg::PP_NUM; j++) begin
      win = op2_pad[2*j +: 3];
      case (win)
        3'b001,
        3'b010:  mult = mcand_pos;      // +1
        3'b011:  mult = mcand_dbl;      // +2
        3'b100:  mult = mcand_neg_dbl;  // -2
        3'b101,
        3'b110:  mult = mcand_neg;      // -1
        default: mult = '0;             // 000 and 111
      endcase
      // weight 4^j, bits above the product width fall off
      pp_o[j] = mult << (2 * j);
    end
  end

endmodule

// ==== hdl/mul_wallace_tree.sv ====
`timescale 1ns/1ps

module mul_wallace_tree (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [mul_pkg::PROD_W-1:0] pp_i [mul_pkg::PP_NUM],
  output logic [mul_pkg::PROD_W-1:0] final_sum_o
);

  localparam int PROD_W     = mul_pkg::PROD_W;
  localparam int PP_NUM     = mul_pkg::PP_NUM;
  localparam int TREE_DEPTH = mul_pkg::TREE_DEPTH;

  // row count entering a given layer
  function automatic int rows_at(input int layer);
    int rows;
    rows = PP_NUM;
    for (int k = 0; k < layer; k++) begin
      rows = mul_pkg::csa_out_rows(rows);
    end
    return rows;
  endfunction

  logic [PROD_W-1:0] pp_q [PP_NUM];

  // partial product bank, loaded every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      pp_q <= '{default: '0};
    end else begin
      pp_q <= pp_i;
    end
  end

  // 33 -> 22 -> 15 -> 10 -> 7 -> 5 -> 4 -> 3 -> 2
  for (genvar i = 0; i < TREE_DEPTH; i++) begin : g_layer
    localparam int IN_ROWS  = rows_at(i);
    localparam int OUT_ROWS = mul_pkg::csa_out_rows(IN_ROWS);

    logic [PROD_W-1:0] rows_in  [IN_ROWS];
    logic [PROD_W-1:0] rows_out [OUT_ROWS];

    if (i == 0) begin : g_first
      assign rows_in = pp_q;
    end else begin : g_next
      assign rows_in = g_layer[i-1].rows_out;
    end

    mul_csa_layer #(
      .IN_ROWS (IN_ROWS)
    ) csa_i (
      .rows_i (rows_in),
      .rows_o (rows_out)
    );
  end

  logic [PROD_W-1:0] sum_row;
  logic [PROD_W-1:0] carry_row;

  assign sum_row   = g_layer[TREE_DEPTH-1].rows_out[0];
  assign carry_row = g_layer[TREE_DEPTH-1].rows_out[1];

  // single carry propagate add
  assign final_sum_o = sum_row + carry_row;

endmodule

// ==== hdl/mul_ctrl.sv ====
`timescale 1ns/1ps

module mul_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       mul_valid_i,
  input  logic [mul_pkg::XLEN-1:0]   rs1_data_i,
  input  logic [mul_pkg::XLEN-1:0]   rs2_data_i,
  input  logic                       rs1_signed_i,
  input  logic                       rs2_signed_i,
  input  logic [mul_pkg::PROD_W-1:0] final_sum_i,
  output logic [mul_pkg::XLEN-1:0]   op1_o,
  output logic [mul_pkg::XLEN-1:0]   op2_o,
  output logic                       op1_signed_o,
  output logic                       op2_signed_o,
  output logic                       mul_ready_o,
  output mul_pkg::product_u          mul_out_o
);

  logic [1:0]        state_q;
  logic              ready_q;
  mul_pkg::product_u result_q;

  logic [mul_pkg::XLEN-1:0] op1_q;
  logic [mul_pkg::XLEN-1:0] op2_q;
  logic                     op1_signed_q;
  logic                     op2_signed_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= mul_pkg::ST_IDLE;
      ready_q      <= 1'b0;
      result_q     <= '0;
      op1_q        <= '0;
      op2_q        <= '0;
      op1_signed_q <= 1'b0;
      op2_signed_q <= 1'b0;
    end else begin
      case (state_q)
        mul_pkg::ST_IDLE: begin
          ready_q <= 1'b0;  // end of pulse
          if (mul_valid_i) begin
            state_q      <= mul_pkg::ST_BOOTH;
            op1_q        <= rs1_data_i;
            op2_q        <= rs2_data_i;
            op1_signed_q <= rs1_signed_i;
            op2_signed_q <= rs2_signed_i;
          end
        end
        mul_pkg::ST_BOOTH: begin
          // pp rows land in the tree on this edge
          if (mul_valid_i) begin
            state_q <= mul_pkg::ST_WAIT;
          end else begin
            state_q  <= mul_pkg::ST_IDLE;
            result_q <= '0;
          end
        end
        mul_pkg::ST_WAIT: begin
          state_q <= mul_pkg::ST_IDLE;
          if (mul_valid_i) begin
            ready_q       <= 1'b1;
            result_q.full <= final_sum_i;
          end else begin
            result_q <= '0;  // aborted
          end
        end
        default: begin
          state_q <= mul_pkg::ST_IDLE;
        end
      endcase
    end
  end

  assign op1_o        = op1_q;
  assign op2_o        = op2_q;
  assign op1_signed_o = op1_signed_q;
  assign op2_signed_o = op2_signed_q;
  assign mul_ready_o  = ready_q;
  assign mul_out_o    = result_q;

endmodule

// ==== hdl/mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [mul_pkg::XLEN-1:0] rs1_data_i,
  input  logic [mul_pkg::XLEN-1:0] rs2_data_i,
  input  logic                     rs1_signed_i,
  input  logic                     rs2_signed_i,
  input  logic                     mul_valid_i,
  output logic                     mul_ready_o,
  output mul_pkg::product_u        mul_out_o
);

  logic [mul_pkg::XLEN-1:0]   op1;
  logic [mul_pkg::XLEN-1:0]   op2;
  logic                       op1_signed;
  logic                       op2_signed;
  logic [mul_pkg::PROD_W-1:0] pp [mul_pkg::PP_NUM];
  logic [mul_pkg::PROD_W-1:0] final_sum;

  mul_ctrl ctrl_i (
    .clk          (clk),
    .rst          (rst),
    .mul_valid_i  (mul_valid_i),
    .rs1_data_i   (rs1_data_i),
    .rs2_data_i   (rs2_data_i),
    .rs1_signed_i (rs1_signed_i),
    .rs2_signed_i (rs2_signed_i),
    .final_sum_i  (final_sum),
    .op1_o        (op1),
    .op2_o        (op2),
    .op1_signed_o (op1_signed),
    .op2_signed_o (op2_signed),
    .mul_ready_o  (mul_ready_o),
    .mul_out_o    (mul_out_o)
  );

  mul_booth_r4 booth_i (
    .op1_i        (op1),
    .op2_i        (op2),
    .op1_signed_i (op1_signed),
    .op2_signed_i (op2_signed),
    .pp_o         (pp)
  );

  mul_wallace_tree tree_i (
    .clk         (clk),
    .rst         (rst),
    .pp_i        (pp),
    .final_sum_o (final_sum)
  );

endmodule

// ==== dv/mul_unit_checker.sv ====
`timescale 1ns/1ps

module mul_unit_checker (
  input logic              clk,
  input logic              rst,
  input logic              mul_valid_i,
  input logic              ready_i,
  input mul_pkg::product_u out_i
);

  // ready is a single cycle pulse
  ready_single_pulse: assert property (
    @(posedge clk) disable iff (rst) ready_i |=> !ready_i
  ) else $error("mul_ready_o stayed high for two cycles in a row");

  // a pulse needs valid held over the accept edge and both datapath edges
  ready_after_valid: assert property (
    @(posedge clk) disable iff (rst)
      ready_i |-> ($past(mul_valid_i, 1) && $past(mul_valid_i, 2) && $past(mul_valid_i, 3))
  ) else $error("mul_ready_o rose without mul_valid_i held for three edges");

  // outputs still at reset values right after release
  reset_outputs_clear: assert property (
    @(posedge clk) $fell(rst) |-> (!ready_i && out_i.full == '0)
  ) else $error("outputs not cleared in the cycle after reset release");

endmodule

bind mul_unit mul_unit_checker checker_i (
  .clk         (clk),
  .rst         (rst),
  .mul_valid_i (mul_valid_i),
  .ready_i     (mul_ready_o),
  .out_i       (mul_out_o)
);

// ==== dv/mul_unit_tb.sv ====
`timescale 1ns/1ps

module mul_unit_tb;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DLY   = 10;
  localparam int OP_LIMIT    = 10;              // cycles allowed per operation
  localparam int RANDOM_OPS  = 200;
  localparam int OP_COUNT    = 16 + 32 + RANDOM_OPS + 4 + 5;
  localparam int WATCHDOG_NS = (OP_COUNT * OP_LIMIT + 20) * CLK_PERIOD;

  logic                     clk;
  logic                     rst;
  logic [mul_pkg::XLEN-1:0] rs1_data;
  logic [mul_pkg::XLEN-1:0] rs2_data;
  logic                     rs1_signed;
  logic                     rs2_signed;
  logic                     mul_valid;
  logic                     mul_ready;
  mul_pkg::product_u        mul_out;

  int error_count  = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  mul_pkg::product_u held;  // what mul_out should show between pulses

  mul_unit mul_unit_i (
    .clk          (clk),
    .rst          (rst),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .rs1_signed_i (rs1_signed),
    .rs2_signed_i (rs2_signed),
    .mul_valid_i  (mul_valid),
    .mul_ready_o  (mul_ready),
    .mul_out_o    (mul_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("=== FAIL ===");
    $finish;
  end

  // extend each operand by its own flag, then a 128-bit product
  function automatic mul_pkg::product_u model_product(input logic [63:0] a,
                                                      input logic [63:0] b,
                                                      input logic sa,
                                                      input logic sb);
    logic [127:0]      ea;
    logic [127:0]      eb;
    mul_pkg::product_u p;
    ea = sa ? {{64{a[63]}}, a} : {64'd0, a};
    eb = sb ? {{64{b[63]}}, b} : {64'd0, b};
    p.full = ea * eb;
    return p;
  endfunction

  task automatic compare_product(input string name, input mul_pkg::product_u exp,
                                 input mul_pkg::product_u act);
    if (exp.full !== act.full) begin
      $display("[ERROR] %s expected hi=%h lo=%h actual hi=%h lo=%h", name,
               exp.half.hi, exp.half.lo, act.half.hi, act.half.lo);
      error_count++;
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[ERROR] %s expected ready=%b actual ready=%b", name, exp, act);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  // full handshake entered and left just after a rising edge
  task automatic run_op(input string name, input logic [63:0] a, input logic [63:0] b,
                        input logic sa, input logic sb);
    mul_pkg::product_u exp;
    int                cycles;
    bit                got;
    exp = model_product(a, b, sa, sb);
    rs1_data   = a;
    rs2_data   = b;
    rs1_signed = sa;
    rs2_signed = sb;
    mul_valid  = 1'b1;
    cycles = 0;
    got    = 0;
    while (!got && cycles < OP_LIMIT) begin
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
      if (mul_ready) begin
        got = 1;
      end else begin
        compare_product({name, " hold"}, held, mul_out);
      end
    end
    mul_valid = 1'b0;  // low again before the next edge
    if (!got) begin
      $display("%s: ready never came within %0d cycles", name, OP_LIMIT);
      error_count++;
    end else begin
      compare_product(name, exp, mul_out);
      held = exp;
    end
    @(posedge clk);
    #DRIVE_DLY;
    compare_flag({name, " pulse end"}, 1'b0, mul_ready);
  endtask

  task automatic test_reset();
    int errors_before;
    errors_before = error_count;
    compare_flag("reset", 1'b0, mul_ready);
    compare_product("reset", '0, mul_out);
    report_test("reset", errors_before);
  endtask

  task automatic test_unsigned_corners();
    int          errors_before;
    logic [63:0] vals [4];
    errors_before = error_count;
    vals = '{64'd0, 64'd1, '1, 64'h8000_0000_0000_0000};
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        run_op($sformatf("unsigned_%0d_%0d", i, j), vals[i], vals[j], 1'b0, 1'b0);
      end
    end
    report_test("unsigned_corners", errors_before);
  endtask

  // (1,1) is mulh, (1,0) is mulhsu
  task automatic test_signed_corners();
    int          errors_before;
    logic        sb;
    logic [63:0] vals [4];
    errors_before = error_count;
    vals = '{64'h8000_0000_0000_0000, '1, 64'd1, 64'd0};
    for (int p = 0; p < 2; p++) begin
      sb = (p == 0);
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          run_op($sformatf("signed_%0d_%0d_%0d", p, i, j), vals[i], vals[j], 1'b1, sb);
        end
      end
    end
    report_test("signed_corners", errors_before);
  endtask

  task automatic test_random();
    int          errors_before;
    logic [63:0] a;
    logic [63:0] b;
    logic        sa;
    logic        sb;
    errors_before = error_count;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      a  = {$urandom(), $urandom()};
      b  = {$urandom(), $urandom()};
      sa = ($urandom_range(1, 0) == 1);
      sb = ($urandom_range(1, 0) == 1);
      run_op($sformatf("random_%0d", n), a, b, sa, sb);
    end
    report_test("random", errors_before);
  endtask

  // valid dropped after the accept edge, then after the pp register edge
  task automatic test_abort();
    int    errors_before;
    bit    seen;
    string name;
    errors_before = error_count;
    for (int d = 1; d <= 2; d++) begin
      name       = $sformatf("abort_%0d", d);
      rs1_data   = 64'h0123_4567_89ab_cdef;
      rs2_data   = 64'hfedc_ba98_7654_3210;
      rs1_signed = 1'b1;
      rs2_signed = 1'b0;
      mul_valid  = 1'b1;
      repeat (d) begin
        @(posedge clk);
        #DRIVE_DLY;
      end
      mul_valid = 1'b0;
      @(posedge clk);  // controller sees valid low here
      #DRIVE_DLY;
      compare_product({name, " abort edge"}, '0, mul_out);
      seen = mul_ready;
      repeat (OP_LIMIT) begin
        @(posedge clk);
        #DRIVE_DLY;
        if (mul_ready) begin
          seen = 1;
        end
      end
      if (seen) begin
        $display("%s: a ready pulse appeared after valid was dropped early", name);
        error_count++;
      end
      compare_product(name, '0, mul_out);
      held = '0;
      run_op({name, "_recovery"}, 64'hdead_beef_0000_0007, 64'h0000_0000_0000_0ff1,
             1'b0, 1'b0);
    end
    report_test("abort", errors_before);
  endtask

  // valid only low for the one edge after each pulse
  task automatic test_back_to_back();
    int errors_before;
    errors_before = error_count;
    run_op("b2b_0", 64'd3, 64'd5, 1'b0, 1'b0);
    run_op("b2b_1", '1, '1, 1'b1, 1'b1);
    run_op("b2b_2", 64'h8000_0000_0000_0000, 64'd2, 1'b1, 1'b0);
    run_op("b2b_3", 64'h7fff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff, 1'b0, 1'b0);
    run_op("b2b_4", 64'h1234_5678_9abc_def0, '1, 1'b0, 1'b1);
    report_test("back_to_back", errors_before);
  endtask

  initial begin
    void'($urandom(31));
    rst        = 1'b1;
    rs1_data   = '0;
    rs2_data   = '0;
    rs1_signed = 1'b0;
    rs2_signed = 1'b0;
    mul_valid  = 1'b0;
    held       = '0;
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;

    test_reset();
    test_unsigned_corners();
    test_signed_corners();
    test_random();
    test_abort();
    test_back_to_back();

    $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hdl/mul_pkg.sv
hdl/mul_csa_layer.sv
hdl/mul_booth_r4.sv
hdl/mul_wallace_tree.sv
hdl/mul_ctrl.sv
hdl/mul_unit.sv
dv/mul_unit_checker.sv
dv/mul_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the multiply unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f \
  --top-module mul_unit_tb \
  -o sim_mul_unit

./obj_dir/sim_mul_unit > sim.log 2>&1 || true
cat sim.log

if grep -qx "=== PASS ===" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
